//--- cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// layer geometry
`define IMG_SIDE   8
`define KER_SIDE   3
`define CONV_SIDE  6
`define POOL_SIDE  3
`define FC_LEN     9

// flattened map lengths
`define IMG_LEN    (`IMG_SIDE * `IMG_SIDE)
`define KER_LEN    (`KER_SIDE * `KER_SIDE)
`define CONV_LEN   (`CONV_SIDE * `CONV_SIDE)
`define POOL_LEN   (`POOL_SIDE * `POOL_SIDE)

// arithmetic right shift of the window sum before relu
`define CONV_SHIFT 4

// configuration word address map
`define ADDR_W     7
`define ADDR_IMG   0
`define ADDR_KER   64
`define ADDR_FCW   73
`define ADDR_BIAS  82

`endif

//--- cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // image and feature map value
    typedef logic [7:0] pixel_t;
    // kernel and fc weight
    typedef logic signed [7:0] weight_t;
    typedef logic signed [23:0] acc_t;
    // fc output and bias
    typedef logic signed [15:0] result_t;

    // relu followed by clamp into the pixel range
    function automatic pixel_t relu_clamp(acc_t sum);
        if (sum < 0) begin
            return '0;
        end
        if (sum > 24'sd255) begin
            return 8'hff;
        end
        return sum[7:0];
    endfunction

    // saturate an accumulator into signed 16 bits
    function automatic result_t sat_result(acc_t sum);
        if (sum > 24'sd32767) begin
            return 16'sh7fff;
        end
        if (sum < -24'sd32768) begin
            return 16'sh8000;
        end
        return sum[15:0];
    endfunction

endpackage

`default_nettype wire

//--- cnn_weight_regs.sv
`default_nettype none
`timescale 1ns/1ps
`include "cnn_defines.svh"

module cnn_weight_regs (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cfg_wr,
    input  wire [`ADDR_W-1:0]       cfg_addr,
    input  wire [15:0]              cfg_data,
    input  wire                     busy,
    output cnn_pkg::pixel_t         img [`IMG_LEN],
    output cnn_pkg::weight_t        kernel [`KER_LEN],
    output cnn_pkg::weight_t        fc_weight [`FC_LEN],
    output cnn_pkg::result_t        bias
);
    import cnn_pkg::*;

    // offsets into each address range
    logic [`ADDR_W-1:0] img_off;
    logic [`ADDR_W-1:0] ker_off;
    logic [`ADDR_W-1:0] fcw_off;

    assign img_off = cfg_addr - `ADDR_W'(`ADDR_IMG);
    assign ker_off = cfg_addr - `ADDR_W'(`ADDR_KER);
    assign fcw_off = cfg_addr - `ADDR_W'(`ADDR_FCW);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IMG_LEN; i++) begin
                img[i] <= '0;
            end
            for (int i = 0; i < `KER_LEN; i++) begin
                kernel[i] <= '0;
            end
            for (int i = 0; i < `FC_LEN; i++) begin
                fc_weight[i] <= '0;
            end
            bias <= '0;
        end else if (cfg_wr && !busy) begin
            // image and weights take the low byte, bias the whole word
            if (cfg_addr < `ADDR_W'(`ADDR_KER)) begin
                img[img_off[5:0]] <= pixel_t'(cfg_data[7:0]);
            end else if (cfg_addr < `ADDR_W'(`ADDR_FCW)) begin
                kernel[ker_off[3:0]] <= weight_t'(cfg_data[7:0]);
            end else if (cfg_addr < `ADDR_W'(`ADDR_BIAS)) begin
                fc_weight[fcw_off[3:0]] <= weight_t'(cfg_data[7:0]);
            end else if (cfg_addr == `ADDR_W'(`ADDR_BIAS)) begin
                bias <= result_t'(cfg_data);
            end
            // anything above the bias word is dropped
        end
    end

endmodule

`default_nettype wire

//--- cnn_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module cnn_sequencer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 req,
    output logic                ack,
    output logic                busy,
    output logic                conv_start,
    input  wire                 conv_done,
    output logic                pool_start,
    input  wire                 pool_done,
    output logic                fc_start,
    input  wire                 fc_done,
    input  wire cnn_pkg::result_t fc_result,
    output cnn_pkg::result_t    value
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CONV,
        S_POOL,
        S_FC,
        S_DONE,
        S_RELEASE
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            ack        <= 1'b0;
            busy       <= 1'b0;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            fc_start   <= 1'b0;
            value      <= '0;
        end else begin
            // start strobes last a single cycle
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            fc_start   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req) begin
                        busy       <= 1'b1;
                        conv_start <= 1'b1;
                        state      <= S_CONV;
                    end
                end
                S_CONV: begin
                    if (conv_done) begin
                        pool_start <= 1'b1;
                        state      <= S_POOL;
                    end
                end
                S_POOL: begin
                    if (pool_done) begin
                        fc_start <= 1'b1;
                        state    <= S_FC;
                    end
                end
                S_FC: begin
                    if (fc_done) begin
                        value <= fc_result;
                        ack   <= 1'b1;
                        state <= S_DONE;
                    end
                end
                // host holding req keeps us parked here
                S_DONE: begin
                    if (!req) begin
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    ack   <= 1'b0;
                    busy  <= 1'b0;
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- cnn_conv_layer.sv
`default_nettype none
`timescale 1ns/1ps
`include "cnn_defines.svh"

module cnn_conv_layer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire cnn_pkg::pixel_t    img [`IMG_LEN],
    input  wire cnn_pkg::weight_t   kernel [`KER_LEN],
    output logic                    done,
    output cnn_pkg::pixel_t         conv_map [`CONV_LEN]
);
    import cnn_pkg::*;

    logic       running;
    // top-left corner of the current window
    logic [2:0] row;
    logic [2:0] col;
    acc_t       win_sum;
    acc_t       win_scaled;

    // nine products of the window, pixels zero-extended, weights sign-extended
    always_comb begin
        win_sum = '0;
        for (int kr = 0; kr < `KER_SIDE; kr++) begin
            for (int kc = 0; kc < `KER_SIDE; kc++) begin
                win_sum = win_sum
                    + acc_t'(img[(int'(row) + kr) * `IMG_SIDE + int'(col) + kc])
                    * acc_t'(kernel[kr * `KER_SIDE + kc]);
            end
        end
    end

    assign win_scaled = win_sum >>> `CONV_SHIFT;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            row     <= '0;
            col     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                row     <= '0;
                col     <= '0;
            end else if (running) begin
                if (col == 3'(`CONV_SIDE - 1)) begin
                    col <= '0;
                    if (row == 3'(`CONV_SIDE - 1)) begin
                        // last window written this cycle
                        running <= 1'b0;
                        done    <= 1'b1;
                    end else begin
                        row <= row + 3'd1;
                    end
                end else begin
                    col <= col + 3'd1;
                end
            end
        end
    end

    // output map holds until the next start
    always_ff @(posedge clk) begin
        if (running) begin
            conv_map[int'(row) * `CONV_SIDE + int'(col)] <= relu_clamp(win_scaled);
        end
    end

endmodule

`default_nettype wire

//--- cnn_pool_layer.sv
`default_nettype none
`timescale 1ns/1ps
`include "cnn_defines.svh"

module cnn_pool_layer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire cnn_pkg::pixel_t    conv_map [`CONV_LEN],
    output logic                    done,
    output cnn_pkg::pixel_t         pool_map [`POOL_LEN]
);
    import cnn_pkg::*;

    logic       running;
    logic [1:0] row;
    logic [1:0] col;
    int         base;
    pixel_t     top_max;
    pixel_t     bot_max;
    pixel_t     blk_max;

    // upper-left element of the 2x2 block in the conv map
    assign base = int'(row) * 2 * `CONV_SIDE + int'(col) * 2;

    assign top_max = (conv_map[base] > conv_map[base + 1]) ?
                     conv_map[base] : conv_map[base + 1];
    assign bot_max = (conv_map[base + `CONV_SIDE] > conv_map[base + `CONV_SIDE + 1]) ?
                     conv_map[base + `CONV_SIDE] : conv_map[base + `CONV_SIDE + 1];
    assign blk_max = (top_max > bot_max) ? top_max : bot_max;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            row     <= '0;
            col     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                row     <= '0;
                col     <= '0;
            end else if (running) begin
                if (col == 2'(`POOL_SIDE - 1)) begin
                    col <= '0;
                    if (row == 2'(`POOL_SIDE - 1)) begin
                        running <= 1'b0;
                        done    <= 1'b1;
                    end else begin
                        row <= row + 2'd1;
                    end
                end else begin
                    col <= col + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            pool_map[int'(row) * `POOL_SIDE + int'(col)] <= blk_max;
        end
    end

endmodule

`default_nettype wire

//--- cnn_fc_layer.sv
`default_nettype none
`timescale 1ns/1ps
`include "cnn_defines.svh"

module cnn_fc_layer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire cnn_pkg::pixel_t    pool_map [`POOL_LEN],
    input  wire cnn_pkg::weight_t   fc_weight [`FC_LEN],
    input  wire cnn_pkg::result_t   bias,
    output logic                    done,
    output cnn_pkg::result_t        fc_result
);
    import cnn_pkg::*;

    logic       running;
    logic [3:0] idx;
    acc_t       acc;
    acc_t       acc_next;

    // one pooled value times its weight per cycle
    assign acc_next = acc + acc_t'(pool_map[idx]) * acc_t'(fc_weight[idx]);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            idx     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                idx     <= '0;
            end else if (running) begin
                if (idx == 4'(`FC_LEN - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    idx <= idx + 4'd1;
                end
            end
        end
    end

    // accumulator seeded with the bias, result saturated on the last term
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= acc_t'(bias);
        end else if (running) begin
            acc <= acc_next;
            if (idx == 4'(`FC_LEN - 1)) begin
                fc_result <= sat_result(acc_next);
            end
        end
    end

endmodule

`default_nettype wire

//--- cnn_top.sv
`default_nettype none
`timescale 1ns/1ps
`include "cnn_defines.svh"

module cnn_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cfg_wr,
    input  wire [`ADDR_W-1:0]   cfg_addr,
    input  wire [15:0]          cfg_data,
    input  wire                 req,
    output logic                ack,
    output cnn_pkg::result_t    value
);
    import cnn_pkg::*;

    // sequencer to layers
    logic    busy;
    logic    conv_start;
    logic    conv_done;
    logic    pool_start;
    logic    pool_done;
    logic    fc_start;
    logic    fc_done;

    // register block outputs
    pixel_t  img [`IMG_LEN];
    weight_t kernel [`KER_LEN];
    weight_t fc_weight [`FC_LEN];
    result_t bias;

    // inter-layer maps
    pixel_t  conv_map [`CONV_LEN];
    pixel_t  pool_map [`POOL_LEN];
    result_t fc_result;

    cnn_weight_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .busy      (busy),
        .img       (img),
        .kernel    (kernel),
        .fc_weight (fc_weight),
        .bias      (bias)
    );

    cnn_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ack        (ack),
        .busy       (busy),
        .conv_start (conv_start),
        .conv_done  (conv_done),
        .pool_start (pool_start),
        .pool_done  (pool_done),
        .fc_start   (fc_start),
        .fc_done    (fc_done),
        .fc_result  (fc_result),
        .value      (value)
    );

    // layer 1, 3x3 convolution
    cnn_conv_layer u_conv (
        .clk      (clk),
        .rst      (rst),
        .start    (conv_start),
        .img      (img),
        .kernel   (kernel),
        .done     (conv_done),
        .conv_map (conv_map)
    );

    // layer 2, 2x2 max-pool
    cnn_pool_layer u_pool (
        .clk      (clk),
        .rst      (rst),
        .start    (pool_start),
        .conv_map (conv_map),
        .done     (pool_done),
        .pool_map (pool_map)
    );

    // layer 3, single fc neuron
    cnn_fc_layer u_fc (
        .clk       (clk),
        .rst       (rst),
        .start     (fc_start),
        .pool_map  (pool_map),
        .fc_weight (fc_weight),
        .bias      (bias),
        .done      (fc_done),
        .fc_result (fc_result)
    );

endmodule

`default_nettype wire

//--- cnn_checker.sv
`default_nettype none
`timescale 1ns/1ps
`include "cnn_defines.svh"

module cnn_checker (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cfg_wr,
    input  wire [`ADDR_W-1:0]       cfg_addr,
    input  wire [15:0]              cfg_data,
    input  wire                     req,
    input  wire                     ack,
    input  wire cnn_pkg::result_t   value,
    output int                      err_count,
    output int                      check_count
);
    import cnn_pkg::*;

    // cycles of busy without ack before the request counts as lost
    localparam int ACK_LIMIT = 150;

    // updated by the testbench as each test begins
    string test_name = "startup";

    // reference copy of the configuration registers
    int   img_m [`IMG_LEN];
    int   ker_m [`KER_LEN];
    int   fcw_m [`FC_LEN];
    int   bias_m;

    // busy from req taken in idle until ack falls
    logic busy_m;
    logic release_m;
    logic ack_q;
    logic rst_q;
    int   wait_cycles;

    // conv, relu and clamp, max-pool, then fc with saturation
    function automatic int model_value();
        int conv_m [`CONV_LEN];
        int pool_m [`POOL_LEN];
        int sum;
        int base;
        for (int r = 0; r < `CONV_SIDE; r++) begin
            for (int c = 0; c < `CONV_SIDE; c++) begin
                sum = 0;
                for (int kr = 0; kr < `KER_SIDE; kr++) begin
                    for (int kc = 0; kc < `KER_SIDE; kc++) begin
                        sum += img_m[(r + kr) * `IMG_SIDE + c + kc] * ker_m[kr * `KER_SIDE + kc];
                    end
                end
                sum = sum >>> `CONV_SHIFT;
                conv_m[r * `CONV_SIDE + c] = (sum < 0) ? 0 : ((sum > 255) ? 255 : sum);
            end
        end
        for (int i = 0; i < `POOL_LEN; i++) begin
            base = (i / `POOL_SIDE) * 2 * `CONV_SIDE + (i % `POOL_SIDE) * 2;
            sum = conv_m[base];
            if (conv_m[base + 1] > sum) sum = conv_m[base + 1];
            if (conv_m[base + `CONV_SIDE] > sum) sum = conv_m[base + `CONV_SIDE];
            if (conv_m[base + `CONV_SIDE + 1] > sum) sum = conv_m[base + `CONV_SIDE + 1];
            pool_m[i] = sum;
        end
        sum = bias_m;
        for (int i = 0; i < `FC_LEN; i++) begin
            sum += pool_m[i] * fcw_m[i];
        end
        if (sum > 32767) sum = 32767;
        if (sum < -32768) sum = -32768;
        return sum;
    endfunction

    always @(posedge clk) begin
        int expected;
        rst_q <= rst;
        ack_q <= ack;
        if (rst) begin
            img_m       = '{default: 0};
            ker_m       = '{default: 0};
            fcw_m       = '{default: 0};
            bias_m      = 0;
            busy_m      <= 1'b0;
            release_m   <= 1'b0;
            wait_cycles <= 0;
            err_count   = 0;
            check_count = 0;
        end else begin
            // first cycle out of reset
            if (rst_q) begin
                check_count++;
                if (value !== '0 || ack !== 1'b0) begin
                    $display(
                        "Error: test %s reset, expected ack 0 value 0 actual ack %0b value %0d",
                        test_name, ack, value);
                    err_count++;
                end
            end
            if (cfg_wr && !busy_m) begin
                if (cfg_addr < `ADDR_KER) img_m[cfg_addr] = cfg_data[7:0];
                else if (cfg_addr < `ADDR_FCW) ker_m[cfg_addr - `ADDR_KER] = $signed(cfg_data[7:0]);
                else if (cfg_addr < `ADDR_BIAS) fcw_m[cfg_addr - `ADDR_FCW] = $signed(cfg_data[7:0]);
                else if (cfg_addr == `ADDR_BIAS) bias_m = $signed(cfg_data);
            end
            if (ack && !ack_q) begin
                if (!busy_m) begin
                    $display("ack rose with no request in progress in test %s", test_name);
                    err_count++;
                end else begin
                    expected = model_value();
                    check_count++;
                    if (int'(value) != expected) begin
                        $display("Error: test %s value, expected %0d actual %0d",
                                 test_name, expected, value);
                        err_count++;
                    end
                end
            end
            if (busy_m && !ack) begin
                wait_cycles <= wait_cycles + 1;
                if (wait_cycles == ACK_LIMIT) begin
                    $display("no ack within %0d cycles of the request in test %s",
                             ACK_LIMIT, test_name);
                    err_count++;
                end
            end else begin
                wait_cycles <= 0;
            end
            if (release_m) begin
                busy_m    <= 1'b0;
                release_m <= 1'b0;
            end else if (busy_m && ack && !req) begin
                release_m <= 1'b1;
            end else if (!busy_m && req) begin
                busy_m <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_cnn.sv
`default_nettype none
`timescale 1ns/1ps
`include "cnn_defines.svh"

module tb_cnn;
    import cnn_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int ACK_WAIT       = 200;
    // about 800 writes and twelve handshakes of about 70 cycles with over 3x margin
    localparam int TIMEOUT_CYCLES = 6000;
    // fill modes for load_range
    // any other mode value is written as its low byte
    localparam int RND       = -1;
    localparam int RND_SMALL = -2;
    localparam int RND_NEG   = -3;

    logic               clk = 1'b0;
    logic               rst;
    logic               cfg_wr;
    logic [`ADDR_W-1:0] cfg_addr;
    logic [15:0]        cfg_data;
    logic               req;
    logic               ack;
    result_t            value;
    int                 err_count;
    int                 check_count;

    integer seed;
    int     pass_count;
    int     fail_count;
    int     err_start;
    int     check_start;
    int     cycle_count;
    logic   local_fail;
    string  cur_test;

    always #10 clk = ~clk;

    cnn_top DUT (
        .clk      (clk),
        .rst      (rst),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .req      (req),
        .ack      (ack),
        .value    (value)
    );

    cnn_checker chk (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .req         (req),
        .ack         (ack),
        .value       (value),
        .err_count   (err_count),
        .check_count (check_count)
    );

    function automatic logic [7:0] pick(input int mode);
        integer r;
        r = $random(seed);
        case (mode)
            RND:       return r[7:0];
            // small signed weights in -16..15
            RND_SMALL: return 8'(r[4:0]) - 8'd16;
            RND_NEG:   return r[7:0] | 8'h80;
            default:   return mode[7:0];
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input int addr, input int data);
        cfg_wr   = 1'b1;
        cfg_addr = `ADDR_W'(addr);
        cfg_data = data[15:0];
        step();
        cfg_wr = 1'b0;
    endtask

    task automatic load_range(input int base, input int count, input int mode);
        for (int i = 0; i < count; i++) begin
            write_word(base + i, int'(pick(mode)));
        end
    endtask

    task automatic load_all_random();
        integer r;
        r = $random(seed);
        load_range(`ADDR_IMG, `IMG_LEN, RND);
        load_range(`ADDR_KER, `KER_LEN, RND_SMALL);
        load_range(`ADDR_FCW, `FC_LEN, RND);
        write_word(`ADDR_BIAS, r);
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < ACK_WAIT) begin
            step();
            n++;
        end
        if (ack !== level) begin
            $display("ack did not go to %0b within %0d cycles in test %s",
                     level, ACK_WAIT, cur_test);
            local_fail = 1'b1;
        end
    endtask

    task automatic run_inference();
        req = 1'b1;
        wait_ack(1'b1);
        req = 1'b0;
        wait_ack(1'b0);
        step();
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        chk.test_name = name;
        err_start     = err_count;
        check_start   = check_count;
        local_fail    = 1'b0;
    endtask

    task automatic end_test(input int want_checks);
        int errs;
        int checks;
        errs   = err_count - err_start;
        checks = check_count - check_start;
        if (errs == 0 && checks == want_checks && !local_fail) begin
            pass_count++;
            $display("test %s: pass (%0d checks)", cur_test, checks);
        end else begin
            fail_count++;
            $display("test %s: FAIL (%0d errors, %0d of %0d checks)",
                     cur_test, errs, checks, want_checks);
        end
    endtask

    initial begin
        seed       = 71;
        rst        = 1'b1;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_data   = '0;
        req        = 1'b0;
        pass_count = 0;
        fail_count = 0;

        begin_test("reset_state");
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        repeat (20) step();
        end_test(1);

        begin_test("random_sets");
        repeat (4) begin
            load_all_random();
            run_inference();
        end
        end_test(4);

        // image stays and only the weights change
        begin_test("kernel_fc_rewrite");
        load_all_random();
        run_inference();
        load_range(`ADDR_KER, `KER_LEN, RND_SMALL);
        load_range(`ADDR_FCW, `FC_LEN, RND);
        // words past the bias address are dropped
        write_word(`ADDR_BIAS + 1, 16'h7abc);
        write_word(127, 16'h00ee);
        run_inference();
        end_test(2);

        begin_test("saturation");
        load_range(`ADDR_IMG, `IMG_LEN, 255);
        load_range(`ADDR_KER, `KER_LEN, 127);
        load_range(`ADDR_FCW, `FC_LEN, 127);
        write_word(`ADDR_BIAS, 1000);
        run_inference();
        load_range(`ADDR_FCW, `FC_LEN, 8'h80);
        run_inference();
        end_test(2);

        begin_test("relu_zero");
        load_all_random();
        load_range(`ADDR_KER, `KER_LEN, RND_NEG);
        run_inference();
        end_test(1);

        // writes during req and during ack must not land
        begin_test("blocked_writes");
        load_all_random();
        run_inference();
        req = 1'b1;
        step();
        load_range(`ADDR_IMG, `IMG_LEN, RND);
        wait_ack(1'b1);
        load_range(`ADDR_KER, `KER_LEN, RND_SMALL);
        req = 1'b0;
        // req is low here but ack is still high
        write_word(`ADDR_BIAS, 16'h4321);
        wait_ack(1'b0);
        step();
        run_inference();
        end_test(3);

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles before the test sequence finished", cycle_count);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
cnn_pkg.sv
cnn_weight_regs.sv
cnn_sequencer.sv
cnn_conv_layer.sv
cnn_pool_layer.sv
cnn_fc_layer.sv
cnn_top.sv
cnn_checker.sv
tb_cnn.sv

//--- Makefile
# Verilator build for the CNN engine testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
